// ==== all.f ====
hw/bchPkg.sv
hw/bchEncoder.sv
hw/bchSyndrome.sv
hw/bchKeyEquation.sv
hw/bchChienSearch.sv
hw/bchControl.sv
hw/bchLink.sv
tests/bchLinkTb.sv

// ==== Bender.yml ====
package:
  name: bchLink

sources:
  - files:
      - hw/bchPkg.sv
      - hw/bchEncoder.sv
      - hw/bchSyndrome.sv
      - hw/bchKeyEquation.sv
      - hw/bchChienSearch.sv
      - hw/bchControl.sv
      - hw/bchLink.sv
  - target: test
    files:
      - tests/bchLinkTb.sv

// ==== tests/bchLinkTb.sv ====
`default_nettype none

module bchLinkTb;
	import bchPkg::*;

	localparam int waitLimit = 100;
	localparam int firstVdout = 21; // cycles from the start cycle
	localparam int busyLow = 26;
	localparam int randomRows = 14;

	typedef struct packed {
		logic [msgLen-1:0] din;
		logic [codeLen-1:0] error;
		logic fewErrors; // at most corrCap flipped bits
		logic restart; // pulse start again while busy
	} testRow;

	logic clk;
	logic reset;
	logic start;
	logic [msgLen-1:0] din;
	logic [codeLen-1:0] error;
	logic busy;
	logic vdout;
	logic [msgLen-1:0] dout;
	logic wrongNow;
	logic wrong;

	testRow rows[$];
	int fixedRows;
	int checks;
	int errors;
	int timeouts;
	logic expWrong; // sticky flag as the rows predict it

	bchLink UUT (
		.clk(clk), .reset(reset), .start(start), .din(din), .error(error),
		.busy(busy), .vdout(vdout), .dout(dout), .wrongNow(wrongNow), .wrong(wrong)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic addRow(input logic [msgLen-1:0] data, input logic [codeLen-1:0] mask,
			input logic few, input logic again);
		testRow row;
		row.din = data;
		row.error = mask;
		row.fewErrors = few;
		row.restart = again;
		rows.push_back(row);
	endtask

	task automatic addRandomRow();
		logic [codeLen-1:0] mask;
		int flips;
		mask = '0;
		flips = $urandom % 7; // up to six flipped bits
		while ($countones(mask) < flips)
			mask[$urandom % codeLen] = 1'b1;
		addRow(msgLen'($urandom), mask, flips <= corrCap, ($urandom % 4) == 0);
	endtask

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b1;
		start = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		expWrong = 1'b0;
		checkValue("vdout", vdout, 1'b0);
		checkValue("busy", busy, 1'b0);
		checkValue("wrongNow", wrongNow, 1'b0);
		checkValue("wrong", wrong, 1'b0);
	endtask

	task automatic runRow(input testRow row);
		int cycles;
		logic [msgLen-1:0] flagged; // wrongNow after each vdout cycle
		logic [msgLen-1:0] decoded;
		logic [msgLen-1:0] refData;
		logic bitNow;
		logic bitWrong;
		@(negedge clk);
		din = row.din;
		error = row.error;
		start = 1'b1;
		@(negedge clk);
		cycles = 1;
		checkValue("busy", busy, 1'b1);
		while (vdout !== 1'b1 && cycles < waitLimit) begin
			if (row.restart && cycles == 8) begin
				start = 1'b1; // DUT is busy, so this start is dropped
				din = ~row.din;
				error = ~row.error;
			end else begin
				start = 1'b0;
				din = row.din;
				error = row.error;
			end
			@(negedge clk);
			cycles++;
		end
		start = 1'b0;
		din = row.din;
		error = row.error;
		if (vdout !== 1'b1) begin
			$display("Timeout: vdout did not rise within %0d cycles of start", waitLimit);
			timeouts++;
			return;
		end
		checkValue("vdout latency", cycles, firstVdout);
		for (int k = 0; k < msgLen; k++) begin
			checkValue("vdout", vdout, 1'b1);
			checkValue("busy", busy, 1'b1);
			@(negedge clk);
			cycles++;
			flagged = {flagged[msgLen-2:0], wrongNow};
		end
		checkValue("vdout", vdout, 1'b0);
		while (busy === 1'b1 && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (busy !== 1'b0) begin
			$display("Timeout: busy did not fall within %0d cycles of start", waitLimit);
			timeouts++;
			return;
		end
		checkValue("busy fall cycle", cycles, busyLow);

		// walk the decoded word msb first, the order the bits left the DUT
		decoded = dout;
		refData = row.din;
		for (int k = 0; k < msgLen; k++) begin
			bitNow = decoded[msgLen-1];
			bitWrong = bitNow != refData[msgLen-1];
			if (row.fewErrors) begin
				checkValue($sformatf("dout[%0d]", msgLen - 1 - k), bitNow, refData[msgLen-1]);
				checkValue($sformatf("wrongNow after bit %0d", k), flagged[msgLen-1], 1'b0);
			end else begin
				checkValue($sformatf("wrongNow after bit %0d", k), flagged[msgLen-1], bitWrong);
				if (bitWrong)
					expWrong = 1'b1;
			end
			decoded = decoded << 1;
			refData = refData << 1;
			flagged = flagged << 1;
		end
		checkValue("wrong", wrong, expWrong);
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		din = '0;
		error = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		expWrong = 1'b0;
		void'($urandom(32'ha9dd));

		addRow(5'h00, 15'h0000, 1'b1, 1'b0);
		addRow(5'h1f, 15'h0000, 1'b1, 1'b0);
		addRow(5'h15, 15'h4000, 1'b1, 1'b0); // first message bit
		addRow(5'h0a, 15'h0001, 1'b1, 1'b0); // last parity bit
		addRow(5'h13, 15'h0201, 1'b1, 1'b0); // parity only
		addRow(5'h0c, 15'h0007, 1'b1, 1'b1);
		addRow(5'h1b, 15'h4410, 1'b1, 1'b0);
		addRow(5'h07, 15'h7c00, 1'b0, 1'b0); // every message bit flipped
		addRow(5'h19, 15'h000f, 1'b0, 1'b1);
		addRow(5'h11, 15'h6006, 1'b0, 1'b0);
		fixedRows = rows.size();
		for (int i = 0; i < randomRows; i++)
			addRandomRow();

		applyReset();
		foreach (rows[i]) begin
			if (i == fixedRows)
				applyReset(); // clears the sticky flag before the random rows
			runRow(rows[i]);
			if (timeouts != 0)
				break;
		end
		if (timeouts == 0)
			applyReset();

		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/bchLink.sv ====
`default_nettype none

module bchLink (
	input wire clk,
	input wire reset,
	input wire start,
	input wire [bchPkg::msgLen-1:0] din,
	input wire [bchPkg::codeLen-1:0] error,
	output logic busy,
	output logic vdout,
	output logic [bchPkg::msgLen-1:0] dout,
	output logic wrongNow,
	output logic wrong
);
	import bchPkg::*;

	logic load;
	logic codeBit;
	logic codeValid;
	logic codeLast;
	logic rxBit;
	logic rxValid;
	logic keyStart;
	logic keyDone;
	logic chienStart;
	logic bitValid;
	logic bitOut;
	bchSyndromes syndromes;
	bchLocator locator;

	bchControl control (
		.clk(clk), .reset(reset), .start(start), .din(din), .error(error),
		.codeBit(codeBit), .codeValid(codeValid), .codeLast(codeLast),
		.keyDone(keyDone), .bitValid(bitValid), .bitOut(bitOut),
		.load(load), .rxBit(rxBit), .rxValid(rxValid),
		.keyStart(keyStart), .chienStart(chienStart), .busy(busy),
		.vdout(vdout), .dout(dout), .wrongNow(wrongNow), .wrong(wrong)
	);

	bchEncoder encoder (
		.clk(clk), .reset(reset), .load(load), .data(din),
		.codeBit(codeBit), .codeValid(codeValid), .codeLast(codeLast)
	);

	bchSyndrome syndrome (
		.clk(clk), .reset(reset), .load(load),
		.rxBit(rxBit), .rxValid(rxValid), .syndromes(syndromes)
	);

	bchKeyEquation keyEquation (
		.clk(clk), .reset(reset), .start(keyStart),
		.syndromes(syndromes), .locator(locator), .done(keyDone)
	);

	bchChienSearch chienSearch (
		.clk(clk), .reset(reset), .load(load),
		.rxBit(rxBit), .rxValid(rxValid), .start(chienStart),
		.locator(locator), .bitValid(bitValid), .bitOut(bitOut)
	);

endmodule

`default_nettype wire

// ==== hw/bchControl.sv ====
`default_nettype none

module bchControl (
	input wire clk,
	input wire reset,
	input wire start,
	input wire [bchPkg::msgLen-1:0] din,
	input wire [bchPkg::codeLen-1:0] error,
	input wire codeBit,
	input wire codeValid,
	input wire codeLast,
	input wire keyDone,
	input wire bitValid,
	input wire bitOut,
	output logic load,
	output logic rxBit,
	output logic rxValid,
	output logic keyStart,
	output logic chienStart,
	output logic busy,
	output logic vdout,
	output logic [bchPkg::msgLen-1:0] dout,
	output logic wrongNow,
	output logic wrong
);
	import bchPkg::*;

	logic [codeLen-1:0] errMask;
	logic [msgLen-1:0] refData;
	logic [msgLen-1:0] assembled;
	logic [2:0] bitCnt;
	logic mismatch;
	logic lastBit;

	assign load = start && !busy; // one word at a time
	assign rxBit = codeBit ^ errMask[codeLen-1]; // channel flips
	assign rxValid = codeValid;
	assign vdout = bitValid;
	assign mismatch = bitValid && bitOut != refData[msgLen-1];
	assign lastBit = bitValid && bitCnt == msgLen - 1;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			keyStart <= 1'b0;
			chienStart <= 1'b0;
			wrongNow <= 1'b0;
			wrong <= 1'b0;
			bitCnt <= '0;
		end else begin
			keyStart <= codeLast;
			chienStart <= keyDone;
			wrongNow <= mismatch;
			if (mismatch)
				wrong <= 1'b1; // sticky
			if (load) begin
				busy <= 1'b1;
				bitCnt <= '0;
			end else if (bitValid) begin
				bitCnt <= bitCnt + 1'b1;
				if (lastBit)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			errMask <= error;
			refData <= din;
		end else begin
			if (codeValid)
				errMask <= errMask << 1;
			if (bitValid) begin
				refData <= refData << 1;
				assembled <= {assembled[msgLen-2:0], bitOut};
			end
		end
		if (lastBit)
			dout <= {assembled[msgLen-2:0], bitOut}; // held until the next word
	end

endmodule

`default_nettype wire

// ==== hw/bchChienSearch.sv ====
`default_nettype none

module bchChienSearch (
	input wire clk,
	input wire reset,
	input wire load,
	input wire rxBit,
	input wire rxValid,
	input wire start,
	input wire bchPkg::bchLocator locator,
	output logic bitValid,
	output logic bitOut
);
	import bchPkg::*;

	bchLocator terms; // sigma_j * alpha^(-j*pos) for the position under test
	gfElem evalSum;
	logic [msgLen-1:0] msgBuf;
	logic [2:0] rxCnt;
	logic [2:0] outCnt;
	logic capture;

	assign capture = rxValid && rxCnt < msgLen;
	assign evalSum = terms.sigma0 ^ terms.sigma1 ^ terms.sigma2 ^ terms.sigma3;
	assign bitOut = msgBuf[msgLen-1] ^ (evalSum == '0); // root means error here

	always_ff @(posedge clk) begin
		if (reset) begin
			bitValid <= 1'b0;
			outCnt <= '0;
			rxCnt <= '0;
		end else begin
			if (load)
				rxCnt <= '0;
			else if (capture)
				rxCnt <= rxCnt + 1'b1;
			if (start) begin
				bitValid <= 1'b1;
				outCnt <= '0;
			end else if (bitValid) begin
				bitValid <= outCnt != msgLen - 1;
				outCnt <= outCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			msgBuf <= '0;
		else if (capture)
			msgBuf <= {msgBuf[msgLen-2:0], rxBit};
		else if (bitValid)
			msgBuf <= msgBuf << 1;
	end

	// alpha^-14 is alpha, so the first load already points at position 14
	always_ff @(posedge clk) begin
		if (start) begin
			terms.sigma0 <= locator.sigma0;
			terms.sigma1 <= gfMul(locator.sigma1, alpha1);
			terms.sigma2 <= gfMul(locator.sigma2, alpha2);
			terms.sigma3 <= gfMul(locator.sigma3, alpha3);
		end else if (bitValid) begin
			terms.sigma1 <= gfMul(terms.sigma1, alpha1);
			terms.sigma2 <= gfMul(terms.sigma2, alpha2);
			terms.sigma3 <= gfMul(terms.sigma3, alpha3);
		end
	end

endmodule

`default_nettype wire

// ==== hw/bchKeyEquation.sv ====
`default_nettype none

module bchKeyEquation (
	input wire clk,
	input wire reset,
	input wire start,
	input wire bchPkg::bchSyndromes syndromes,
	output bchPkg::bchLocator locator,
	output logic done
);
	import bchPkg::*;

	gfElem s2;
	gfElem s4;
	gfElem w0; // S(r) down to S(r-3), r = 2*step+1
	gfElem w1;
	gfElem w2;
	gfElem w3;
	gfElem delta;
	gfElem deltaInv;
	gfElem b0; // correction polynomial, only the low terms matter
	gfElem b1;
	gfElem b2;
	logic [2:0] degree;
	logic [1:0] step;
	logic running;
	logic grow;

	function automatic gfElem gfInv(input gfElem a);
		gfElem a2;
		gfElem a4;
		gfElem a8;
		a2 = gfSquare(a);
		a4 = gfSquare(a2);
		a8 = gfSquare(a4);
		return gfMul(gfMul(a8, a4), a2); // a^14
	endfunction

	// even syndromes of a binary code are squares
	assign s2 = gfSquare(syndromes.s1);
	assign s4 = gfSquare(s2);

	always_comb begin
		case (step)
			2'd0: begin
				w0 = syndromes.s1;
				w1 = '0;
				w2 = '0;
				w3 = '0;
			end
			2'd1: begin
				w0 = syndromes.s3;
				w1 = s2;
				w2 = syndromes.s1;
				w3 = '0;
			end
			default: begin
				w0 = syndromes.s5;
				w1 = s4;
				w2 = syndromes.s3;
				w3 = s2;
			end
		endcase
	end

	assign delta = gfMul(locator.sigma0, w0) ^ gfMul(locator.sigma1, w1)
		^ gfMul(locator.sigma2, w2) ^ gfMul(locator.sigma3, w3);
	assign deltaInv = gfInv(delta);
	assign grow = delta != '0 && degree <= step; // 2L <= r-1
	assign done = running && step == corrCap - 1; // locator settles at the end of this cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			step <= '0;
		end else if (start) begin
			running <= 1'b1;
			step <= '0;
		end else if (running) begin
			running <= step != corrCap - 1;
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			locator.sigma0 <= gfElem'(1);
			locator.sigma1 <= '0;
			locator.sigma2 <= '0;
			locator.sigma3 <= '0;
			b0 <= gfElem'(1);
			b1 <= '0;
			b2 <= '0;
			degree <= '0;
		end else if (running) begin
			locator.sigma1 <= locator.sigma1 ^ gfMul(delta, b0);
			locator.sigma2 <= locator.sigma2 ^ gfMul(delta, b1);
			locator.sigma3 <= locator.sigma3 ^ gfMul(delta, b2);
			b0 <= '0; // constant term is one only for the first step
			if (grow) begin
				b1 <= gfMul(deltaInv, locator.sigma0); // x * sigma / delta
				b2 <= gfMul(deltaInv, locator.sigma1);
				degree <= {step, 1'b1} - degree;
			end else begin
				b1 <= '0; // x^2 * b, skipping the zero even step
				b2 <= b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/bchSyndrome.sv ====
`default_nettype none

module bchSyndrome (
	input wire clk,
	input wire reset,
	input wire load,
	input wire rxBit,
	input wire rxValid,
	output bchPkg::bchSyndromes syndromes
);
	import bchPkg::*;

	gfElem rxElem;

	assign rxElem = {{(fieldBits-1){1'b0}}, rxBit};

	// Horner form, highest codeword position arrives first
	always_ff @(posedge clk) begin
		if (reset || load) begin
			syndromes <= '0;
		end else if (rxValid) begin
			syndromes.s1 <= gfMul(syndromes.s1, alpha1) ^ rxElem;
			syndromes.s3 <= gfMul(syndromes.s3, alpha3) ^ rxElem;
			syndromes.s5 <= gfMul(syndromes.s5, alpha5) ^ rxElem;
		end
	end

endmodule

`default_nettype wire

// ==== hw/bchEncoder.sv ====
`default_nettype none

module bchEncoder (
	input wire clk,
	input wire reset,
	input wire load,
	input wire [bchPkg::msgLen-1:0] data,
	output logic codeBit,
	output logic codeValid,
	output logic codeLast
);
	import bchPkg::*;

	logic [msgLen-1:0] msgReg;
	logic [codeLen-msgLen-1:0] parity;
	logic [3:0] bitCnt;
	logic inMsg;
	logic feedback;

	assign inMsg = bitCnt < msgLen; // first five bits are the message
	assign feedback = msgReg[msgLen-1] ^ parity[codeLen-msgLen-1];
	assign codeBit = inMsg ? msgReg[msgLen-1] : parity[codeLen-msgLen-1];
	assign codeLast = codeValid && bitCnt == codeLen - 1;

	always_ff @(posedge clk) begin
		if (reset) begin
			codeValid <= 1'b0;
			bitCnt <= '0;
		end else if (load) begin
			codeValid <= 1'b1;
			bitCnt <= '0;
		end else if (codeValid) begin
			codeValid <= !codeLast;
			bitCnt <= bitCnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			msgReg <= data;
			parity <= '0;
		end else if (codeValid) begin
			if (inMsg) begin
				msgReg <= msgReg << 1;
				parity <= (parity << 1) ^ (feedback ? genPoly[codeLen-msgLen-1:0] : '0);
			end else begin
				parity <= parity << 1; // remainder goes out high degree first
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/bchPkg.sv ====
`default_nettype none

package bchPkg;

	localparam int codeLen = 15;
	localparam int msgLen = 5;
	localparam int corrCap = 3;
	localparam int fieldBits = 4;

	// x^10+x^8+x^5+x^4+x^2+x+1
	localparam logic [codeLen-msgLen:0] genPoly = 11'b101_0011_0111;

	// x^4+x+1
	localparam logic [fieldBits:0] primPoly = 5'b10011;

	typedef logic [fieldBits-1:0] gfElem; // polynomial basis

	localparam gfElem alpha1 = 4'b0010;
	localparam gfElem alpha2 = 4'b0100;
	localparam gfElem alpha3 = 4'b1000;
	localparam gfElem alpha5 = 4'b0110;

	typedef struct packed {
		gfElem s1;
		gfElem s3;
		gfElem s5;
	} bchSyndromes;

	typedef struct packed {
		gfElem sigma0;
		gfElem sigma1;
		gfElem sigma2;
		gfElem sigma3;
	} bchLocator;

	function automatic gfElem gfMul(input gfElem a, input gfElem b);
		logic [2*fieldBits-2:0] prod;
		prod = '0;
		for (int i = 0; i < fieldBits; i++) begin
			if (b[i])
				prod = prod ^ ({{(fieldBits-1){1'b0}}, a} << i);
		end
		// fold the high terms back down, top one first
		for (int i = 2*fieldBits-2; i >= fieldBits; i--) begin
			if (prod[i])
				prod = prod ^ ({{(fieldBits-2){1'b0}}, primPoly} << (i - fieldBits));
		end
		return prod[fieldBits-1:0];
	endfunction

	function automatic gfElem gfSquare(input gfElem a);
		return gfMul(a, a);
	endfunction

endpackage

`default_nettype wire
